// File: rtl/cw_reg_pkg.sv
`default_nettype none

package cw_reg_pkg;

   localparam int BYTECNT_W = 7;   // Byte index within one register access

   typedef logic [BYTECNT_W-1:0] bytecnt_t;

   // ADC block register map
   localparam logic [7:0] ADDR_ADC_CTRL   = 8'h50;
   localparam logic [7:0] ADDR_VMAG       = 8'h51;
   localparam logic [7:0] ADDR_ADC_SER    = 8'h52;   // Two bytes, byte 1 launches
   localparam logic [7:0] ADDR_ADC_STATUS = 8'h53;

   // Target pin register map
   localparam logic [7:0] ADDR_TARGET_PWR = 8'h58;
   localparam logic [7:0] ADDR_TARGET_IO  = 8'h59;

   // Status register bit positions
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_ERR_BIT  = 1;   // Sticky, write 1 to clear

   // ADC_CTRL layout, bit0 is reset
   typedef struct packed {
      logic oe;
      logic dfs;
      logic reset;
   } adc_ctrl_reg_t;

   // TARGET_IO layout, bit0 is AVR programming
   typedef struct packed {
      logic pdic_val;
      logic pdic_en;
      logic pdid_val;
      logic pdid_en;
      logic nrst_val;
      logic nrst_en;
      logic avrprog;
   } target_io_reg_t;

   typedef struct packed {
      logic [7:0] address;
      bytecnt_t   bytecnt;
      logic [7:0] wdata;
      logic       read;    // One-cycle strobes
      logic       write;
   } reg_bus_t;

endpackage

`default_nettype wire

// File: rtl/cw_pin_pkg.sv
`default_nettype none

package cw_pin_pkg;

   localparam int SER_BITS   = 16;   // Serial config frame length
   localparam int SCLK_DIV   = 4;    // clk_usb cycles per sclk period
   localparam int FLASH_BITS = 4;

   localparam int SCLK_DIV_W = $clog2(SCLK_DIV);
   localparam int SER_CNT_W  = $clog2(SER_BITS);

   typedef logic [SCLK_DIV_W-1:0] div_cnt_t;
   typedef logic [SER_CNT_W-1:0]  bit_cnt_t;
   typedef logic [FLASH_BITS-1:0] flash_cnt_t;

   localparam div_cnt_t DIV_RISE = div_cnt_t'(SCLK_DIV / 2 - 1);   // sclk rises after this
   localparam div_cnt_t DIV_LAST = div_cnt_t'(SCLK_DIV - 1);
   localparam bit_cnt_t BIT_LAST = bit_cnt_t'(SER_BITS - 1);

   typedef struct packed {
      logic oe;
      logic value;
   } pin_drive_t;

   typedef struct packed {
      pin_drive_t nrst;
      pin_drive_t pdid;
      pin_drive_t pdic;
      pin_drive_t mosi;
      pin_drive_t sck;
   } target_pins_t;

   typedef struct packed {
      logic reset;
      logic dfs;
      logic oe;
      logic sclk;
      logic sdata;
      logic sen;     // Active low frame enable
   } adc_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/usb_reg_main.sv
`timescale 1ns/10ps
`default_nettype none

module usb_reg_main (
   input  wire                       clk_usb_i,
   input  wire                       rst_n_i,
   input  wire [7:0]                 usb_addr_i,
   input  wire [7:0]                 usb_data_i,
   input  wire                       usb_rdn_i,
   input  wire                       usb_wrn_i,
   input  wire                       usb_cen_i,
   input  wire                       usb_alen_i,
   input  wire [7:0]                 reg_rdata_i,
   output logic [7:0]                usb_data_o,
   output logic                      usb_isout_o,
   output cw_reg_pkg::reg_bus_t      reg_bus_o
);

   logic                 rdn_s, wrn_s, cen_s, alen_s;   // Sampled host strobes
   logic                 rdn_d, wrn_d;                  // Previous samples for edge detect
   logic [7:0]           addr_s;
   logic [7:0]           data_s;
   logic                 rd_fall_q, wr_fall_q;
   logic [7:0]           addr_q;
   cw_reg_pkg::bytecnt_t bytecnt_q;
   cw_reg_pkg::reg_bus_t bus_q;
   logic [7:0]           rdata_q;
   logic                 isout_q;

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdn_s     <= 1'b1;
         wrn_s     <= 1'b1;
         cen_s     <= 1'b1;
         alen_s    <= 1'b1;
         rdn_d     <= 1'b1;
         wrn_d     <= 1'b1;
         rd_fall_q <= 1'b0;
         wr_fall_q <= 1'b0;
      end else begin
         rdn_s     <= usb_rdn_i;
         wrn_s     <= usb_wrn_i;
         cen_s     <= usb_cen_i;
         alen_s    <= usb_alen_i;
         rdn_d     <= rdn_s;
         wrn_d     <= wrn_s;
         rd_fall_q <= rdn_d && !rdn_s && !cen_s;
         wr_fall_q <= wrn_d && !wrn_s && !cen_s;
      end
   end

   always_ff @(posedge clk_usb_i) begin
      addr_s <= usb_addr_i;
      data_s <= usb_data_i;
   end

   // Address latch, byte counter steps after every access
   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         addr_q    <= '0;
         bytecnt_q <= '0;
      end else if (!alen_s) begin
         addr_q    <= addr_s;
         bytecnt_q <= '0;
      end else if (bus_q.read || bus_q.write) begin
         bytecnt_q <= bytecnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         bus_q <= '0;
      end else begin
         bus_q.address <= addr_q;
         bus_q.bytecnt <= bytecnt_q;
         bus_q.wdata   <= data_s;
         bus_q.read    <= rd_fall_q;
         bus_q.write   <= wr_fall_q;
      end
   end

   // Hold the read byte until the host releases rdn
   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
         isout_q <= 1'b0;
      end else if (bus_q.read) begin
         rdata_q <= reg_rdata_i;
         isout_q <= 1'b1;
      end else if (rdn_s) begin
         isout_q <= 1'b0;
      end
   end

   assign reg_bus_o   = bus_q;
   assign usb_data_o  = rdata_q;
   assign usb_isout_o = isout_q;

   a_rd_wr_excl: assert property (@(posedge clk_usb_i) disable iff (!rst_n_i)
      !(bus_q.read && bus_q.write));

endmodule

`default_nettype wire

// File: rtl/reg_husky_adc.sv
`timescale 1ns/10ps
`default_nettype none

module reg_husky_adc (
   input  wire                       clk_usb_i,
   input  wire                       rst_n_i,
   input  wire cw_reg_pkg::reg_bus_t reg_bus_i,
   input  wire                       adc_sdout_i,
   output logic [7:0]                reg_rdata_o,
   output cw_pin_pkg::adc_ctrl_t     adc_o,
   output logic [4:0]                vmag_o,
   output logic                      adc_err_o
);

   cw_reg_pkg::adc_ctrl_reg_t           ctrl_q;
   logic [4:0]                          vmag_q;
   logic                                err_q;
   logic [7:0]                          tx_lo_q;             // Staged low byte
   logic [cw_pin_pkg::SER_BITS-1:0]     tx_q, tx_d;
   logic [cw_pin_pkg::SER_BITS-1:0]     rx_sh_q;
   logic [cw_pin_pkg::SER_BITS-1:0]     rx_q;                // Last complete SDOUT word
   logic                                busy_q, busy_d;
   cw_pin_pkg::div_cnt_t                div_q, div_d;
   cw_pin_pkg::bit_cnt_t                bit_q, bit_d;
   logic                                sen_q, sclk_q, sdata_q;
   logic                                wr_ctrl, wr_vmag, wr_ser_lo, wr_ser_hi, wr_status;
   logic                                launch, overrun;

   assign wr_ctrl   = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_ADC_CTRL);
   assign wr_vmag   = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_VMAG);
   assign wr_status = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_ADC_STATUS);
   assign wr_ser_lo = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_ADC_SER)
                      && (reg_bus_i.bytecnt == cw_reg_pkg::bytecnt_t'(0));
   assign wr_ser_hi = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_ADC_SER)
                      && (reg_bus_i.bytecnt == cw_reg_pkg::bytecnt_t'(1));
   assign launch    = wr_ser_hi && !busy_q;
   assign overrun   = wr_ser_hi && busy_q;   // Dropped, flagged only

   always_comb begin
      reg_rdata_o = '0;
      case (reg_bus_i.address)
         cw_reg_pkg::ADDR_ADC_CTRL: reg_rdata_o = {5'b0, ctrl_q};
         cw_reg_pkg::ADDR_VMAG:     reg_rdata_o = {3'b0, vmag_q};
         cw_reg_pkg::ADDR_ADC_SER: begin
            if (reg_bus_i.bytecnt == cw_reg_pkg::bytecnt_t'(0))
               reg_rdata_o = rx_q[7:0];
            else if (reg_bus_i.bytecnt == cw_reg_pkg::bytecnt_t'(1))
               reg_rdata_o = rx_q[15:8];
         end
         cw_reg_pkg::ADDR_ADC_STATUS: begin
            reg_rdata_o[cw_reg_pkg::STAT_BUSY_BIT] = busy_q;
            reg_rdata_o[cw_reg_pkg::STAT_ERR_BIT]  = err_q;
         end
         default: ;
      endcase
   end

   // Frame sequencer, MSB first
   always_comb begin
      busy_d = busy_q;
      div_d  = div_q;
      bit_d  = bit_q;
      tx_d   = tx_q;
      if (launch) begin
         busy_d = 1'b1;
         div_d  = '0;
         bit_d  = '0;
         tx_d   = {reg_bus_i.wdata, tx_lo_q};
      end else if (busy_q) begin
         div_d = div_q + 1'b1;
         if (div_q == cw_pin_pkg::DIV_LAST) begin
            bit_d = bit_q + 1'b1;
            tx_d  = {tx_q[cw_pin_pkg::SER_BITS-2:0], 1'b0};
            if (bit_q == cw_pin_pkg::BIT_LAST)
               busy_d = 1'b0;
         end
      end
   end

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q  <= 1'b0;
         div_q   <= '0;
         bit_q   <= '0;
         sen_q   <= 1'b1;
         sclk_q  <= 1'b0;
         sdata_q <= 1'b0;
      end else begin
         busy_q  <= busy_d;
         div_q   <= div_d;
         bit_q   <= bit_d;
         sen_q   <= !busy_d;
         sclk_q  <= (div_d > cw_pin_pkg::DIV_RISE);   // Low half, then high
         sdata_q <= tx_d[cw_pin_pkg::SER_BITS-1];
      end
   end

   always_ff @(posedge clk_usb_i) begin
      if (wr_ser_lo)
         tx_lo_q <= reg_bus_i.wdata;
      tx_q <= tx_d;
      if (busy_q && (div_q == cw_pin_pkg::DIV_RISE))   // sclk rising edge
         rx_sh_q <= {rx_sh_q[cw_pin_pkg::SER_BITS-2:0], adc_sdout_i};
   end

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
         vmag_q <= '0;
         err_q  <= 1'b0;
         rx_q   <= '0;
      end else begin
         if (wr_ctrl)
            ctrl_q <= cw_reg_pkg::adc_ctrl_reg_t'(reg_bus_i.wdata[2:0]);
         if (wr_vmag)
            vmag_q <= reg_bus_i.wdata[4:0];
         if (overrun)
            err_q <= 1'b1;
         else if (wr_status && reg_bus_i.wdata[cw_reg_pkg::STAT_ERR_BIT])
            err_q <= 1'b0;
         if (busy_q && !busy_d)
            rx_q <= rx_sh_q;
      end
   end

   assign adc_o = '{reset: ctrl_q.reset, dfs: ctrl_q.dfs, oe: ctrl_q.oe,
                    sclk: sclk_q, sdata: sdata_q, sen: sen_q};
   assign vmag_o    = vmag_q;
   assign adc_err_o = err_q;

   // sen stays low for one whole frame
   a_sen_frame: assert property (@(posedge clk_usb_i) disable iff (!rst_n_i)
      $rose(adc_o.sen) |->
         !$past(adc_o.sen, cw_pin_pkg::SER_BITS * cw_pin_pkg::SCLK_DIV)
         && $past(adc_o.sen, cw_pin_pkg::SER_BITS * cw_pin_pkg::SCLK_DIV + 1));
   a_sclk_idle: assert property (@(posedge clk_usb_i) disable iff (!rst_n_i)
      adc_o.sen |-> !adc_o.sclk);

endmodule

`default_nettype wire

// File: rtl/reg_target_io.sv
`timescale 1ns/10ps
`default_nettype none

module reg_target_io (
   input  wire                       clk_usb_i,
   input  wire                       rst_n_i,
   input  wire cw_reg_pkg::reg_bus_t reg_bus_i,
   input  wire                       usb_spare0_i,
   input  wire                       sam_mosi_i,
   input  wire                       sam_spck_i,
   input  wire                       target_miso_i,
   output logic [7:0]                reg_rdata_o,
   output cw_pin_pkg::target_pins_t  pins_o,
   output cw_pin_pkg::pin_drive_t    sam_miso_o,
   output logic                      target_poweron_o
);

   logic                       pwr_off_q;   // Starts set so the target floats
   cw_reg_pkg::target_io_reg_t io_q;
   logic                       wr_pwr, wr_io;

   assign wr_pwr = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_TARGET_PWR);
   assign wr_io  = reg_bus_i.write && (reg_bus_i.address == cw_reg_pkg::ADDR_TARGET_IO);

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pwr_off_q <= 1'b1;
         io_q      <= '0;
      end else begin
         if (wr_pwr)
            pwr_off_q <= reg_bus_i.wdata[0];
         if (wr_io)
            io_q <= cw_reg_pkg::target_io_reg_t'(reg_bus_i.wdata[6:0]);
      end
   end

   always_comb begin
      reg_rdata_o = '0;
      case (reg_bus_i.address)
         cw_reg_pkg::ADDR_TARGET_PWR: reg_rdata_o = {7'b0, pwr_off_q};
         cw_reg_pkg::ADDR_TARGET_IO:  reg_rdata_o = {1'b0, io_q};
         default: ;
      endcase
   end

   // Undriven pins carry a zero value
   always_comb begin
      pins_o = '0;
      if (!pwr_off_q) begin
         if (io_q.avrprog) begin
            pins_o.nrst = '{oe: 1'b1, value: usb_spare0_i};   // Reset from the SAM
            pins_o.mosi = '{oe: 1'b1, value: sam_mosi_i};
            pins_o.sck  = '{oe: 1'b1, value: sam_spck_i};
         end else begin
            pins_o.nrst = '{oe: io_q.nrst_en, value: io_q.nrst_en && io_q.nrst_val};
            pins_o.pdid = '{oe: io_q.pdid_en, value: io_q.pdid_en && io_q.pdid_val};
            pins_o.pdic = '{oe: io_q.pdic_en, value: io_q.pdic_en && io_q.pdic_val};
         end
      end
   end

   // MISO back to the SAM ignores target power
   assign sam_miso_o = '{oe: io_q.avrprog, value: io_q.avrprog && target_miso_i};

   assign target_poweron_o = !pwr_off_q;

endmodule

`default_nettype wire

// File: rtl/led_status.sv
`timescale 1ns/10ps
`default_nettype none

module led_status (
   input  wire  clk_usb_i,
   input  wire  rst_n_i,
   input  wire  error_i,
   input  wire  pll_status_i,
   output logic led_adc_o
);

   cw_pin_pkg::flash_cnt_t flash_cnt_q;   // Free running
   logic                   flash;

   always_ff @(posedge clk_usb_i or negedge rst_n_i) begin
      if (!rst_n_i)
         flash_cnt_q <= '0;
      else
         flash_cnt_q <= flash_cnt_q + 1'b1;
   end

   // Square wave with period 2^FLASH_BITS
   assign flash = flash_cnt_q[cw_pin_pkg::FLASH_BITS-1];

   // Fast flash on an internal error, PLL lock state otherwise
   assign led_adc_o = error_i ? flash : !pll_status_i;

endmodule

`default_nettype wire

// File: rtl/cwhusky_top.sv
`timescale 1ns/10ps
`default_nettype none

module cwhusky_top (
   input  wire                       clk_usb_i,
   input  wire                       rst_n_i,
   // Host register bus
   input  wire [7:0]                 usb_addr_i,
   input  wire [7:0]                 usb_data_i,
   input  wire                       usb_rdn_i,
   input  wire                       usb_wrn_i,
   input  wire                       usb_cen_i,
   input  wire                       usb_alen_i,
   output wire [7:0]                 usb_data_o,
   output wire                       usb_isout_o,
   // ADC and VGA
   input  wire                       adc_sdout_i,
   output cw_pin_pkg::adc_ctrl_t     adc_o,
   output wire [4:0]                 vmag_o,
   // Target and SAM pins
   input  wire                       usb_spare0_i,
   input  wire                       sam_mosi_i,
   input  wire                       sam_spck_i,
   input  wire                       target_miso_i,
   output cw_pin_pkg::target_pins_t  pins_o,
   output cw_pin_pkg::pin_drive_t    sam_miso_o,
   output wire                       target_poweron_o,
   // Status
   input  wire                       pll_status_i,
   output wire                       led_adc_o
);

   wire cw_reg_pkg::reg_bus_t reg_bus;
   wire [7:0]                 reg_rdata;
   wire [7:0]                 rdata_adc;
   wire [7:0]                 rdata_tio;
   wire                       adc_err;

   assign reg_rdata = rdata_adc | rdata_tio;   // Unaddressed blocks return zero

   usb_reg_main i_usb_reg_main (
      .clk_usb_i     (clk_usb_i),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .usb_alen_i    (usb_alen_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_isout_o   (usb_isout_o),
      .reg_bus_o     (reg_bus)
   );

   reg_husky_adc i_reg_husky_adc (
      .clk_usb_i     (clk_usb_i),
      .rst_n_i       (rst_n_i),
      .reg_bus_i     (reg_bus),
      .adc_sdout_i   (adc_sdout_i),
      .reg_rdata_o   (rdata_adc),
      .adc_o         (adc_o),
      .vmag_o        (vmag_o),
      .adc_err_o     (adc_err)
   );

   reg_target_io i_reg_target_io (
      .clk_usb_i        (clk_usb_i),
      .rst_n_i          (rst_n_i),
      .reg_bus_i        (reg_bus),
      .usb_spare0_i     (usb_spare0_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .reg_rdata_o      (rdata_tio),
      .pins_o           (pins_o),
      .sam_miso_o       (sam_miso_o),
      .target_poweron_o (target_poweron_o)
   );

   led_status i_led_status (
      .clk_usb_i     (clk_usb_i),
      .rst_n_i       (rst_n_i),
      .error_i       (adc_err),
      .pll_status_i  (pll_status_i),
      .led_adc_o     (led_adc_o)
   );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #2 rst_n_o = 1'b1;   // Released with the stimulus offset
   end

endmodule

`default_nettype wire

// File: tb/tb_cwhusky_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cwhusky_top;

   localparam int RB_ITER   = 8;
   localparam int SER_ITER  = 4;
   localparam int RT_ITER   = 16;
   localparam int POLL_MAX  = 12;
   localparam int ADDR_CYC  = 3;    // Address phase length
   localparam int WR_CYC    = 6;
   localparam int RD_CYC    = 7;
   localparam int RB_CYC    = RB_ITER * 3 * (2 * ADDR_CYC + WR_CYC + RD_CYC);
   localparam int FRAME_CYC = (2 * ADDR_CYC + 2 * WR_CYC + 2 * RD_CYC
                              + POLL_MAX * (ADDR_CYC + RD_CYC));
   localparam int SER_CYC   = (SER_ITER + 1) * FRAME_CYC;
   localparam int LED_CYC   = 4 * (ADDR_CYC + WR_CYC + RD_CYC) + 2 * 16;
   localparam int RT_CYC    = RT_ITER * (2 * (ADDR_CYC + WR_CYC) + 4);
   localparam int CYCLE_LIMIT = 12 + RB_CYC + SER_CYC + LED_CYC + RT_CYC + 200;

   logic                            clk, rst_n;
   logic [7:0]                      usb_addr, usb_data_in;
   logic                            usb_rdn, usb_wrn, usb_cen, usb_alen;
   wire  [7:0]                      usb_data_out;
   wire                             usb_isout;
   logic                            adc_sdout;
   wire  cw_pin_pkg::adc_ctrl_t     adc;
   wire  [4:0]                      vmag;
   logic                            usb_spare0, sam_mosi, sam_spck, target_miso;
   wire  cw_pin_pkg::target_pins_t  pins;
   wire  cw_pin_pkg::pin_drive_t    sam_miso;
   wire                             target_poweron;
   logic                            pll_status;
   wire                             led_adc;

   logic [31:0] rand_state;
   int          mismatches, failures;
   int          cycle_cnt = 0;
   logic [2:0]  sh_ctrl;        // Shadow registers
   logic [4:0]  sh_vmag;
   logic [6:0]  sh_io;
   logic        sh_pwr_off;
   logic        sh_err;
   logic [15:0] exp_tx, sdout_word;
   int          rise_cnt;
   logic        sclk_prev;

   tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   cwhusky_top i_dut (
      .clk_usb_i        (clk),
      .rst_n_i          (rst_n),
      .usb_addr_i       (usb_addr),
      .usb_data_i       (usb_data_in),
      .usb_rdn_i        (usb_rdn),
      .usb_wrn_i        (usb_wrn),
      .usb_cen_i        (usb_cen),
      .usb_alen_i       (usb_alen),
      .usb_data_o       (usb_data_out),
      .usb_isout_o      (usb_isout),
      .adc_sdout_i      (adc_sdout),
      .adc_o            (adc),
      .vmag_o           (vmag),
      .usb_spare0_i     (usb_spare0),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .pins_o           (pins),
      .sam_miso_o       (sam_miso),
      .target_poweron_o (target_poweron),
      .pll_status_i     (pll_status),
      .led_adc_o        (led_adc)
   );

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic logic pin_ok(input cw_pin_pkg::pin_drive_t act,
                                   input cw_pin_pkg::pin_drive_t want);
      return (act.oe === want.oe) && (!want.oe || act.value === want.value);
   endfunction

   task automatic report_mismatch(input string name, input logic [15:0] act,
                                  input logic [15:0] want);
      $display("MISMATCH %s: got %h expected %h", name, act, want);
      mismatches++;
   endtask

   task automatic report_failure(input string what);
      $display("ERROR: %s", what);
      failures++;
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic steps(input int n);
      repeat (n) step();
   endtask

   task automatic randomize_pins();
      logic [31:0] r;
      r = next_rand();
      usb_spare0  = r[16];
      sam_mosi    = r[17];
      sam_spck    = r[18];
      target_miso = r[19];
      pll_status  = r[20];
   endtask

   task automatic set_address(input logic [7:0] addr);
      usb_addr = addr;
      usb_alen = 1'b0;
      steps(2);
      usb_alen = 1'b1;
      step();
   endtask

   task automatic write_byte(input logic [7:0] data);
      usb_data_in = data;
      usb_cen     = 1'b0;
      usb_wrn     = 1'b0;
      steps(4);
      usb_wrn = 1'b1;
      steps(2);
      usb_cen = 1'b1;
   endtask

   // Data is held from the fourth cycle of rdn low
   task automatic read_byte(output logic [7:0] data);
      usb_cen = 1'b0;
      usb_rdn = 1'b0;
      steps(4);
      data = usb_data_out;
      if (usb_isout !== 1'b1) report_failure("usb_isout_o was low during a read");
      step();
      usb_rdn = 1'b1;
      steps(2);
      usb_cen = 1'b1;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      set_address(addr);
      write_byte(data);
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      set_address(addr);
      read_byte(data);
   endtask

   task automatic wait_frame_done(output logic [7:0] status);
      int polls;
      polls  = 0;
      status = 8'h01;
      while (status[cw_reg_pkg::STAT_BUSY_BIT] && polls < POLL_MAX) begin
         read_reg(cw_reg_pkg::ADDR_ADC_STATUS, status);
         polls++;
      end
      if (status[cw_reg_pkg::STAT_BUSY_BIT]) report_failure("serial frame never finished");
   endtask

   // Serial pin model, checks sdata and plays back the SDOUT word
   always @(posedge clk) begin
      #2;
      if (!adc.sen && adc.sclk && !sclk_prev) begin
         if (rise_cnt < cw_pin_pkg::SER_BITS) begin
            if (adc.sdata !== exp_tx[cw_pin_pkg::SER_BITS - 1 - rise_cnt])
               report_mismatch("adc_o.sdata", 16'(adc.sdata),
                               16'(exp_tx[cw_pin_pkg::SER_BITS - 1 - rise_cnt]));
         end
         rise_cnt++;
      end
      if (!adc.sen && !adc.sclk && rise_cnt < cw_pin_pkg::SER_BITS)
         adc_sdout = sdout_word[cw_pin_pkg::SER_BITS - 1 - rise_cnt];
      if (adc.sen && adc.sclk) report_failure("sclk went high outside a frame");
      sclk_prev = adc.sclk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         failures++;
         $display("ERROR: run stopped at the cycle limit of %0d", CYCLE_LIMIT);
         $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_reset_state();
      logic [7:0] rd;
      if (target_poweron !== 1'b0) report_mismatch("target_poweron_o", 16'(target_poweron), 0);
      if ({pins.nrst.oe, pins.pdid.oe, pins.pdic.oe, pins.mosi.oe, pins.sck.oe} !== 5'b0)
         report_failure("a target pin is driven after reset");
      if (sam_miso.oe !== 1'b0) report_mismatch("sam_miso_o.oe", 16'(sam_miso.oe), 0);
      if (adc.sen !== 1'b1) report_mismatch("adc_o.sen", 16'(adc.sen), 1);
      if (adc.sclk !== 1'b0) report_mismatch("adc_o.sclk", 16'(adc.sclk), 0);
      if ({adc.oe, adc.dfs, adc.reset} !== 3'b0)
         report_failure("ADC control pins set after reset");
      if (usb_isout !== 1'b0) report_mismatch("usb_isout_o", 16'(usb_isout), 0);
      if (led_adc !== !pll_status) report_mismatch("led_adc_o", 16'(led_adc), 16'(!pll_status));
      read_reg(cw_reg_pkg::ADDR_TARGET_PWR, rd);
      if (rd !== 8'h01) report_mismatch("TARGET_PWR readback", 16'(rd), 16'h01);
   endtask

   task automatic test_readback();
      logic [31:0] r;
      logic [7:0]  rd;
      repeat (RB_ITER) begin
         r       = next_rand();
         sh_ctrl = r[26:24];
         sh_vmag = r[20:16];
         sh_io   = r[14:8];
         write_reg(cw_reg_pkg::ADDR_ADC_CTRL, r[31:24]);
         read_reg(cw_reg_pkg::ADDR_ADC_CTRL, rd);
         if (rd !== {5'b0, sh_ctrl}) report_mismatch("ADC_CTRL readback", 16'(rd), 16'(sh_ctrl));
         if ({adc.oe, adc.dfs, adc.reset} !== sh_ctrl)
            report_mismatch("adc_o control bits", 16'({adc.oe, adc.dfs, adc.reset}), 16'(sh_ctrl));
         write_reg(cw_reg_pkg::ADDR_VMAG, r[23:16]);
         read_reg(cw_reg_pkg::ADDR_VMAG, rd);
         if (rd !== {3'b0, sh_vmag}) report_mismatch("VMAG readback", 16'(rd), 16'(sh_vmag));
         if (vmag !== sh_vmag) report_mismatch("vmag_o", 16'(vmag), 16'(sh_vmag));
         write_reg(cw_reg_pkg::ADDR_TARGET_IO, r[15:8]);
         read_reg(cw_reg_pkg::ADDR_TARGET_IO, rd);
         if (rd !== {1'b0, sh_io}) report_mismatch("TARGET_IO readback", 16'(rd), 16'(sh_io));
      end
   endtask

   task automatic run_frame(input logic [15:0] word, input logic [15:0] rx_word);
      logic [7:0] lo, hi, status;
      exp_tx     = word;
      sdout_word = rx_word;
      rise_cnt   = 0;
      write_reg(cw_reg_pkg::ADDR_ADC_SER, word[7:0]);
      write_byte(word[15:8]);   // Launches the frame
      wait_frame_done(status);
      if (status[cw_reg_pkg::STAT_ERR_BIT] !== sh_err) report_failure("unexpected overrun flag");
      if (rise_cnt != cw_pin_pkg::SER_BITS)
         report_failure($sformatf("frame had %0d sclk rising edges", rise_cnt));
      read_reg(cw_reg_pkg::ADDR_ADC_SER, lo);
      read_byte(hi);
      if ({hi, lo} !== rx_word) report_mismatch("ADC_SER readback", {hi, lo}, rx_word);
   endtask

   task automatic test_serial();
      logic [31:0] r1, r2;
      repeat (SER_ITER) begin
         r1 = next_rand();
         r2 = next_rand();
         run_frame(r1[31:16], r2[31:16]);
      end
   endtask

   task automatic test_overrun();
      logic [31:0] r1, r2;
      logic [7:0]  status;
      logic        seen0, seen1;
      r1         = next_rand();
      r2         = next_rand();
      exp_tx     = r1[31:16];
      sdout_word = r2[31:16];
      rise_cnt   = 0;
      write_reg(cw_reg_pkg::ADDR_ADC_SER, r1[23:16]);
      write_byte(r1[31:24]);
      write_reg(cw_reg_pkg::ADDR_ADC_SER, r2[23:16]);
      write_byte(r2[31:24]);   // Still busy, dropped
      sh_err = 1'b1;
      wait_frame_done(status);
      if (status !== 8'h02) report_mismatch("ADC_STATUS", 16'(status), 16'h02);
      if (rise_cnt != cw_pin_pkg::SER_BITS) report_failure("overrun disturbed the running frame");
      seen0 = 1'b0;
      seen1 = 1'b0;
      repeat (2 ** cw_pin_pkg::FLASH_BITS) begin   // PLL status held steady
         step();
         seen0 = seen0 || (led_adc === 1'b0);
         seen1 = seen1 || (led_adc === 1'b1);
      end
      if (!(seen0 && seen1)) report_failure("LED did not flash while the error was set");
      write_reg(cw_reg_pkg::ADDR_ADC_STATUS, 8'h02);
      sh_err = 1'b0;
      read_reg(cw_reg_pkg::ADDR_ADC_STATUS, status);
      if (status !== 8'h00) report_mismatch("ADC_STATUS", 16'(status), 16'h00);
      repeat (16) begin
         randomize_pins();
         step();
         if (led_adc !== !pll_status)
            report_mismatch("led_adc_o", 16'(led_adc), 16'(!pll_status));
      end
   endtask

   task automatic check_routing();
      cw_pin_pkg::target_pins_t want;
      cw_pin_pkg::pin_drive_t   want_miso;
      want = '0;
      if (!sh_pwr_off) begin
         if (sh_io[0]) begin
            want.nrst = '{oe: 1'b1, value: usb_spare0};
            want.mosi = '{oe: 1'b1, value: sam_mosi};
            want.sck  = '{oe: 1'b1, value: sam_spck};
         end else begin
            want.nrst = '{oe: sh_io[1], value: sh_io[2]};
            want.pdid = '{oe: sh_io[3], value: sh_io[4]};
            want.pdic = '{oe: sh_io[5], value: sh_io[6]};
         end
      end
      want_miso = '{oe: sh_io[0], value: target_miso};   // Power state plays no part
      if (!pin_ok(pins.nrst, want.nrst))
         report_mismatch("pins_o.nrst", 16'(pins.nrst), 16'(want.nrst));
      if (!pin_ok(pins.pdid, want.pdid))
         report_mismatch("pins_o.pdid", 16'(pins.pdid), 16'(want.pdid));
      if (!pin_ok(pins.pdic, want.pdic))
         report_mismatch("pins_o.pdic", 16'(pins.pdic), 16'(want.pdic));
      if (!pin_ok(pins.mosi, want.mosi))
         report_mismatch("pins_o.mosi", 16'(pins.mosi), 16'(want.mosi));
      if (!pin_ok(pins.sck, want.sck))
         report_mismatch("pins_o.sck", 16'(pins.sck), 16'(want.sck));
      if (!pin_ok(sam_miso, want_miso))
         report_mismatch("sam_miso_o", 16'(sam_miso), 16'(want_miso));
      if (target_poweron !== !sh_pwr_off)
         report_mismatch("target_poweron_o", 16'(target_poweron), 16'(!sh_pwr_off));
   endtask

   task automatic test_routing();
      logic [31:0] r;
      for (int i = 0; i < RT_ITER; i++) begin
         r          = next_rand();
         sh_pwr_off = i[0];   // Alternate power on and off
         sh_io      = r[22:16];
         write_reg(cw_reg_pkg::ADDR_TARGET_PWR, {r[31:25], sh_pwr_off});
         write_reg(cw_reg_pkg::ADDR_TARGET_IO, r[23:16]);
         repeat (4) begin
            randomize_pins();
            step();
            check_routing();
         end
      end
   endtask

   initial begin
      rand_state  = 32'h41218757;
      mismatches  = 0;
      failures    = 0;
      usb_addr    = '0;
      usb_data_in = '0;
      usb_rdn     = 1'b1;
      usb_wrn     = 1'b1;
      usb_cen     = 1'b1;
      usb_alen    = 1'b1;
      adc_sdout   = 1'b0;
      exp_tx      = '0;
      sdout_word  = '0;
      rise_cnt    = 0;
      sclk_prev   = 1'b0;
      sh_ctrl     = '0;
      sh_vmag     = '0;
      sh_io       = '0;
      sh_pwr_off  = 1'b1;
      sh_err      = 1'b0;
      randomize_pins();
      @(posedge rst_n);
      step();
      check_reset_state();
      test_readback();
      test_serial();
      test_overrun();
      test_routing();
      $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
      if (mismatches + failures == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
rtl/cw_reg_pkg.sv
rtl/cw_pin_pkg.sv
rtl/usb_reg_main.sv
rtl/reg_husky_adc.sv
rtl/reg_target_io.sv
rtl/led_status.sv
rtl/cwhusky_top.sv
tb/tb_clk_gen.sv
tb/tb_cwhusky_top.sv

// File: Makefile
TOP := tb_cwhusky_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
